//--- BranchResolve.f
+incdir+include
src/BranchPkg.sv
src/BranchDecoder.sv
src/BranchUnit.sv
src/BranchSelector.sv
src/BranchResolve.sv
sim/BranchResolve_tb.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP ?= BranchResolve_tb
RTL_TOP ?= BranchResolve
FILELIST ?= BranchResolve.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --timing --timescale $(TIMESCALE)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+include --top-module $(RTL_TOP) \
		src/BranchPkg.sv src/BranchDecoder.sv src/BranchUnit.sv \
		src/BranchSelector.sv src/BranchResolve.sv
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Failure found in $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/branch_macros.svh
`ifndef BRANCH_MACROS_SVH
`define BRANCH_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SQN_W 8        // Sequence number, compared by signed difference.
`define PC_W 32        // Program counter.
`define XLEN 32        // Operand width.
`define FETCHID_W 5    // Fetch block tag.
`define HIST_W 16      // Global branch history.
`define REG_IDX_W 5    // Return stack index.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Redirect sources
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Two branch units, the memory ordering check and the ROB trap slot.
`define NUM_REDIRECT_SRC 4

`endif

//--- sim/BranchResolve_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_macros.svh"

module BranchResolve_tb;
    localparam int NUM_ROWS = 24;
    localparam int MAX_CYCLES = NUM_ROWS * 4 + 50;
    localparam int NONE = 4; // No redirect expected.

    logic clk, rst, mispredFlush;
    logic u0IssueValid, u1IssueValid, u0PredTaken, u1PredTaken;
    BranchPkg::BranchInstr u0Instr, u1Instr;
    logic [`PC_W-1:0] u0Pc, u1Pc, u0PredTarget, u1PredTarget;
    logic [`XLEN-1:0] u0SrcA, u0SrcB, u1SrcA, u1SrcB;
    logic [`SQN_W-1:0] u0SqN, u0LoadSqN, u0StoreSqN, u1SqN, u1LoadSqN, u1StoreSqN;
    logic [`FETCHID_W-1:0] u0FetchID, u1FetchID;
    logic [`REG_IDX_W-1:0] u0RIdx, u1RIdx;
    logic [`HIST_W-1:0] u0History, u1History;
    logic violTaken, trapTaken, trapFlush;
    logic [`PC_W-1:0] violDstPC, trapDstPC;
    logic [`SQN_W-1:0] violSqN, violLoadSqN, violStoreSqN, trapSqN, trapLoadSqN, trapStoreSqN;
    logic [`FETCHID_W-1:0] violFetchID, trapFetchID;
    logic [`REG_IDX_W-1:0] violRIdx, trapRIdx;
    logic [`HIST_W-1:0] violHistory, trapHistory;
    logic redirTaken, redirFlush, branchMispr;
    logic [`PC_W-1:0] redirDstPC;
    logic [`SQN_W-1:0] redirSqN, redirLoadSqN, redirStoreSqN;
    logic [`FETCHID_W-1:0] redirFetchID;
    logic [`REG_IDX_W-1:0] redirRIdx;
    logic [`HIST_W-1:0] redirHistory;

    // One stimulus row per cycle.
    int rowTest [NUM_ROWS];
    logic rowIv [NUM_ROWS][2];
    logic [31:0] rowInstr [NUM_ROWS][2];
    logic [31:0] rowPc [NUM_ROWS][2];
    logic rowPredT [NUM_ROWS][2];
    logic [31:0] rowPredTgt [NUM_ROWS][2];
    logic [7:0] rowSq [NUM_ROWS][2];
    logic rowEq [NUM_ROWS][2];
    logic rowViol [NUM_ROWS];
    logic [7:0] rowViolSq [NUM_ROWS];
    logic [31:0] rowViolDst [NUM_ROWS];
    logic rowTrap [NUM_ROWS];
    logic rowTrapFlush [NUM_ROWS];
    logic [7:0] rowTrapSq [NUM_ROWS];
    logic [31:0] rowTrapDst [NUM_ROWS];
    logic rowMf [NUM_ROWS];
    int rowWin [NUM_ROWS];
    logic rowMispr [NUM_ROWS];
    int nRows;

    // Reference model state per unit.
    logic mV1 [2], mMis1 [2], mTk1 [2], mV2 [2], mTk2 [2];
    logic [31:0] mDst1 [2], mDst2 [2];
    logic [7:0] mSq1 [2], mSq2 [2], mFlushSqN;
    logic nV1 [2], nMis1 [2], nTk1 [2], nV2 [2], nTk2 [2];
    logic [31:0] nDst1 [2], nDst2 [2];
    logic [7:0] nSq1 [2], nSq2 [2], nFlushSqN;
    logic [31:0] drvA [2], drvB [2];

    integer seed = 32'h1c63_0818;
    int cycles, testErrs, totalErrs, testsPassed, testsFailed;
    string testName [1:6];

    BranchResolve UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] condOp(input logic [2:0] cc, input logic [27:0] off);
        return {1'b0, cc, off};
    endfunction

    function automatic logic [31:0] jumpOp(input logic ind, input logic [29:0] imm);
        return {1'b1, ind, imm};
    endfunction

    function automatic logic older(input logic [7:0] a, input logic [7:0] b);
        return $signed(a - b) < 0; // Sequence numbers wrap.
    endfunction

    function automatic logic [15:0] histOf(input logic [7:0] sq);
        return {8'hA5, sq};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Table building
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic clearRow();
        for (int u = 0; u < 2; u++) begin
            rowIv[nRows][u] = 1'b0;
            rowInstr[nRows][u] = '0;
            rowPc[nRows][u] = '0;
            rowPredT[nRows][u] = 1'b0;
            rowPredTgt[nRows][u] = '0;
            rowSq[nRows][u] = '0;
            rowEq[nRows][u] = 1'b0;
        end
        rowViol[nRows] = 1'b0;
        rowViolSq[nRows] = '0;
        rowViolDst[nRows] = '0;
        rowTrap[nRows] = 1'b0;
        rowTrapFlush[nRows] = 1'b0;
        rowTrapSq[nRows] = '0;
        rowTrapDst[nRows] = '0;
        rowMf[nRows] = 1'b0;
    endtask

    task automatic setIssue(input int u, input logic [31:0] ins, input logic [31:0] pc,
                            input logic pt, input logic [31:0] ptgt, input logic [7:0] sq,
                            input logic eq);
        rowIv[nRows][u] = 1'b1;
        rowInstr[nRows][u] = ins;
        rowPc[nRows][u] = pc;
        rowPredT[nRows][u] = pt;
        rowPredTgt[nRows][u] = ptgt;
        rowSq[nRows][u] = sq;
        rowEq[nRows][u] = eq;
    endtask

    // Taken NE branch that was predicted not taken.
    task automatic mispredict(input int u, input logic [31:0] pc, input logic [7:0] sq);
        setIssue(u, condOp(3'd1, 28'h80), pc, 1'b0, pc + 32'd4, sq, 1'b0);
    endtask

    task automatic endRow(input int test, input int win, input logic mispr);
        rowTest[nRows] = test;
        rowWin[nRows] = win;
        rowMispr[nRows] = mispr;
        nRows++;
        if (nRows < NUM_ROWS) begin
            clearRow();
        end
    endtask

    task automatic buildTable();
        nRows = 0;
        clearRow();
        setIssue(0, condOp(3'd1, 28'h40), 32'h100, 1'b0, 32'h104, 8'd10, 1'b1);
        setIssue(1, jumpOp(1'b0, 30'h40), 32'h200, 1'b1, 32'h240, 8'd11, 1'b0);
        endRow(1, NONE, 0);
        endRow(1, NONE, 0);
        endRow(1, NONE, 0);
        setIssue(0, condOp(3'd0, 28'h20), 32'h300, 1'b0, 32'h304, 8'd20, 1'b1);
        endRow(2, NONE, 0);
        setIssue(1, jumpOp(1'b1, 30'h10), 32'h400, 1'b1, 32'h0, 8'd15, 1'b0);
        endRow(2, NONE, 0);
        endRow(2, 0, 1);
        endRow(2, 1, 1);
        mispredict(0, 32'h500, 8'd30);
        setIssue(1, condOp(3'd0, 28'h80), 32'h600, 1'b1, 32'h680, 8'd28, 1'b0);
        endRow(3, NONE, 0);
        endRow(3, NONE, 0);
        endRow(3, 1, 1);
        mispredict(0, 32'h700, 8'd250); // Older across the wrap.
        mispredict(1, 32'h800, 8'd3);
        endRow(3, NONE, 0);
        endRow(3, NONE, 0);
        endRow(3, 0, 1);
        mispredict(0, 32'h900, 8'd40);
        mispredict(1, 32'hA00, 8'd41);
        endRow(4, NONE, 0);
        endRow(4, NONE, 0);
        rowTrap[nRows] = 1'b1;
        rowTrapFlush[nRows] = 1'b1;
        rowTrapSq[nRows] = 8'd45;
        rowTrapDst[nRows] = 32'h8000;
        endRow(4, 3, 0);
        mispredict(0, 32'hB00, 8'd50);
        mispredict(1, 32'hC00, 8'd42);
        endRow(5, NONE, 0);
        endRow(5, NONE, 0);
        rowMf[nRows] = 1'b1;
        endRow(5, 1, 0);
        mispredict(0, 32'hD00, 8'd60);
        endRow(6, NONE, 0);
        rowViol[nRows] = 1'b1;
        rowViolSq[nRows] = 8'd55;
        rowViolDst[nRows] = 32'h5000;
        mispredict(1, 32'hE00, 8'd70); // Killed at issue.
        endRow(6, 2, 0);
        endRow(6, NONE, 0);
        endRow(6, NONE, 0);
        endRow(6, NONE, 0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drive, model and check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic driveRow(input int i);
        for (int u = 0; u < 2; u++) begin
            drvA[u] = $random(seed);
            drvB[u] = rowEq[i][u] ? drvA[u] : ~drvA[u];
        end
        u0IssueValid = rowIv[i][0];
        u0Instr = rowInstr[i][0];
        u0Pc = rowPc[i][0];
        u0SrcA = drvA[0];
        u0SrcB = drvB[0];
        u0PredTaken = rowPredT[i][0];
        u0PredTarget = rowPredTgt[i][0];
        u0SqN = rowSq[i][0];
        u0LoadSqN = rowSq[i][0] + 8'd1;
        u0StoreSqN = rowSq[i][0] + 8'd2;
        u0FetchID = rowSq[i][0][4:0];
        u0History = histOf(rowSq[i][0]);
        u0RIdx = rowSq[i][0][4:0] ^ 5'd5;
        u1IssueValid = rowIv[i][1];
        u1Instr = rowInstr[i][1];
        u1Pc = rowPc[i][1];
        u1SrcA = drvA[1];
        u1SrcB = drvB[1];
        u1PredTaken = rowPredT[i][1];
        u1PredTarget = rowPredTgt[i][1];
        u1SqN = rowSq[i][1];
        u1LoadSqN = rowSq[i][1] + 8'd1;
        u1StoreSqN = rowSq[i][1] + 8'd2;
        u1FetchID = rowSq[i][1][4:0];
        u1History = histOf(rowSq[i][1]);
        u1RIdx = rowSq[i][1][4:0] ^ 5'd5;
        violTaken = rowViol[i];
        violDstPC = rowViolDst[i];
        violSqN = rowViolSq[i];
        violLoadSqN = rowViolSq[i] + 8'd1;
        violStoreSqN = rowViolSq[i] + 8'd2;
        violFetchID = rowViolSq[i][4:0];
        violHistory = histOf(rowViolSq[i]);
        violRIdx = rowViolSq[i][4:0] ^ 5'd5;
        trapTaken = rowTrap[i];
        trapFlush = rowTrapFlush[i];
        trapDstPC = rowTrapDst[i];
        trapSqN = rowTrapSq[i];
        trapLoadSqN = rowTrapSq[i] + 8'd1;
        trapStoreSqN = rowTrapSq[i] + 8'd2;
        trapFetchID = rowTrapSq[i][4:0];
        trapHistory = histOf(rowTrapSq[i]);
        trapRIdx = rowTrapSq[i][4:0] ^ 5'd5;
        mispredFlush = rowMf[i];
    endtask

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, got);
            testErrs++;
        end
    endtask

    task automatic evalModel(input int i);
        logic v [4];
        logic [7:0] sq [4];
        logic [31:0] dst [4];
        logic [15:0] hist [4];
        logic redir, tk, mis, elig;
        logic [31:0] imm, tgt, nxt, a, b;
        logic [7:0] rsq;
        int win;
        for (int u = 0; u < 2; u++) begin
            v[u] = mV2[u];
            sq[u] = mSq2[u];
            dst[u] = mDst2[u];
            hist[u] = {histOf(mSq2[u]) << 1} | 16'(mTk2[u]); // Shifted history.
        end
        v[2] = rowViol[i];
        sq[2] = rowViolSq[i];
        dst[2] = rowViolDst[i];
        hist[2] = histOf(rowViolSq[i]);
        v[3] = rowTrap[i];
        sq[3] = rowTrapSq[i];
        dst[3] = rowTrapDst[i];
        hist[3] = histOf(rowTrapSq[i]);
        win = NONE;
        for (int s = 0; s < 4; s++) begin
            elig = v[s] && (!rowMf[i] || older(sq[s], mFlushSqN));
            if (elig && (s == 3 || win == NONE || older(sq[s], sq[win]))) win = s;
        end
        redir = win != NONE;
        assert (win == rowWin[i]) else begin
            $display("Reference model picks slot %0d but the table expects slot %0d",
                     win, rowWin[i]);
            testErrs++;
        end
        checkVal("redirTaken", 32'(redirTaken), 32'(rowWin[i] != NONE));
        checkVal("branchMispr", 32'(branchMispr), 32'(rowMispr[i]));
        if (redir) begin
            checkVal("redirFlush", 32'(redirFlush), 32'(win == 3 && rowTrapFlush[i]));
            checkVal("redirDstPC", redirDstPC, dst[win]);
            checkVal("redirSqN", 32'(redirSqN), 32'(sq[win]));
            checkVal("redirLoadSqN", 32'(redirLoadSqN), 32'(sq[win] + 8'd1));
            checkVal("redirStoreSqN", 32'(redirStoreSqN), 32'(sq[win] + 8'd2));
            checkVal("redirFetchID", 32'(redirFetchID), 32'(sq[win][4:0]));
            checkVal("redirHistory", 32'(redirHistory), 32'(hist[win]));
            checkVal("redirRIdx", 32'(redirRIdx), 32'(sq[win][4:0] ^ 5'd5));
        end
        rsq = redir ? sq[win] : 8'd0;
        nFlushSqN = redir ? rsq : mFlushSqN;
        for (int u = 0; u < 2; u++) begin
            nV2[u] = mV1[u] && mMis1[u] && !(redir && older(rsq, mSq1[u]));
            nDst2[u] = mDst1[u];
            nSq2[u] = mSq1[u];
            nTk2[u] = mTk1[u];
            a = drvA[u];
            b = drvB[u];
            if (rowInstr[i][u][31]) begin
                tk = 1'b1;
                imm = {{2{rowInstr[i][u][29]}}, rowInstr[i][u][29:0]};
                tgt = rowInstr[i][u][30] ? a + imm : rowPc[i][u] + imm;
            end else begin
                imm = {{4{rowInstr[i][u][27]}}, rowInstr[i][u][27:0]};
                tgt = rowPc[i][u] + imm;
                case (rowInstr[i][u][30:28])
                    3'd0: tk = a == b;
                    3'd1: tk = a != b;
                    3'd2: tk = $signed(a) < $signed(b);
                    3'd3: tk = $signed(a) >= $signed(b);
                    3'd4: tk = a < b;
                    3'd5: tk = a >= b;
                    default: tk = 1'b1;
                endcase
            end
            nxt = tk ? tgt : rowPc[i][u] + 32'd4;
            mis = (tk != rowPredT[i][u]) || (nxt != rowPredTgt[i][u]);
            nV1[u] = rowIv[i][u] && !(redir && older(rsq, rowSq[i][u]));
            nMis1[u] = mis;
            nTk1[u] = tk;
            nDst1[u] = nxt;
            nSq1[u] = rowSq[i][u];
        end
    endtask

    task automatic commitModel();
        for (int u = 0; u < 2; u++) begin
            mV1[u] = nV1[u];
            mMis1[u] = nMis1[u];
            mTk1[u] = nTk1[u];
            mDst1[u] = nDst1[u];
            mSq1[u] = nSq1[u];
            mV2[u] = nV2[u];
            mTk2[u] = nTk2[u];
            mDst2[u] = nDst2[u];
            mSq2[u] = nSq2[u];
        end
        mFlushSqN = nFlushSqN;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        testName[1] = "correct prediction";
        testName[2] = "conditional and indirect mispredict";
        testName[3] = "oldest of two units with wrap";
        testName[4] = "trap override";
        testName[5] = "suppression during flush";
        testName[6] = "violation kills younger branch";
        testErrs = 0;
        totalErrs = 0;
        testsPassed = 0;
        testsFailed = 0;
        buildTable();
        for (int u = 0; u < 2; u++) begin
            mV1[u] = 1'b0;
            mV2[u] = 1'b0;
        end
        mFlushSqN = '0;
        rst = 1'b1;
        driveRow(NUM_ROWS - 1); // Idle row sets every input.
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < nRows; i++) begin
            @(negedge clk);
            driveRow(i);
            #1;
            evalModel(i);
            if (i == nRows - 1 || rowTest[i + 1] != rowTest[i]) begin
                $display("Test %0d %s: %s", rowTest[i], testName[rowTest[i]],
                         testErrs == 0 ? "ok" : "errors");
                if (testErrs == 0) testsPassed++;
                else testsFailed++;
                totalErrs += testErrs;
                testErrs = 0;
            end
            @(posedge clk);
            commitModel();
        end
        $display("Tests passed %0d, failed %0d, check errors %0d",
                 testsPassed, testsFailed, totalErrs);
        if (totalErrs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the table did not finish", cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/BranchDecoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_macros.svh"

module BranchDecoder (
    input wire BranchPkg::BranchInstr instr,
    input wire [`PC_W-1:0] pc,
    input wire [`XLEN-1:0] srcA,
    output BranchPkg::BranchCond cond,
    output logic [`XLEN-1:0] imm,
    output logic isIndirect,
    output logic [`PC_W-1:0] target
);
    import BranchPkg::*;

    always_comb begin
        cond = COND_ALWAYS;
        isIndirect = 1'b0;
        if (instr.j.kind == KIND_JUMP) begin
            imm = {{(`XLEN-30){instr.j.imm[29]}}, instr.j.imm}; // Sign extend.
            isIndirect = instr.j.indirect;
        end else begin
            imm = {{(`XLEN-28){instr.c.offset[27]}}, instr.c.offset};
            case (instr.c.cc)
                3'd0: cond = COND_EQ;
                3'd1: cond = COND_NE;
                3'd2: cond = COND_LT;
                3'd3: cond = COND_GE;
                3'd4: cond = COND_LTU;
                3'd5: cond = COND_GEU;
                default: cond = COND_ALWAYS; // Codes 6 and 7 are unconditional.
            endcase
        end
    end

    // Indirect jumps are relative to srcA, everything else to the PC.
    assign target = isIndirect ? `PC_W'(srcA + imm) : pc + `PC_W'(imm);

endmodule

`default_nettype wire

//--- src/BranchPkg.sv
`default_nettype none

package BranchPkg;

    // Compare kinds. Jumps decode as COND_ALWAYS.
    typedef enum logic [2:0] {
        COND_EQ     = 3'd0,
        COND_NE     = 3'd1,
        COND_LT     = 3'd2,
        COND_GE     = 3'd3,
        COND_LTU    = 3'd4,
        COND_GEU    = 3'd5,
        COND_ALWAYS = 3'd6
    } BranchCond;

    localparam logic KIND_JUMP = 1'b1; // Top bit of every branch word.

    // Conditional form, PC relative.
    typedef struct packed {
        logic        kind;
        logic [2:0]  cc;
        logic [27:0] offset;
    } BranchCondForm;

    // Jump form, PC or register relative.
    typedef struct packed {
        logic        kind;
        logic        indirect;
        logic [29:0] imm;
    } BranchJumpForm;

    typedef union packed {
        BranchCondForm c;
        BranchJumpForm j;
    } BranchInstr;

endpackage

`default_nettype wire

//--- src/BranchResolve.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_macros.svh"

module BranchResolve (
    input wire clk,
    input wire rst,
    input wire u0IssueValid, u1IssueValid,
    input wire BranchPkg::BranchInstr u0Instr, u1Instr,
    input wire [`PC_W-1:0] u0Pc, u1Pc,
    input wire [`XLEN-1:0] u0SrcA, u0SrcB, u1SrcA, u1SrcB,
    input wire u0PredTaken, u1PredTaken,
    input wire [`PC_W-1:0] u0PredTarget, u1PredTarget,
    input wire [`SQN_W-1:0] u0SqN, u0LoadSqN, u0StoreSqN,
    input wire [`SQN_W-1:0] u1SqN, u1LoadSqN, u1StoreSqN,
    input wire [`FETCHID_W-1:0] u0FetchID, u1FetchID,
    input wire [`HIST_W-1:0] u0History, u1History,
    input wire [`REG_IDX_W-1:0] u0RIdx, u1RIdx,
    input wire violTaken,
    input wire [`PC_W-1:0] violDstPC,
    input wire [`SQN_W-1:0] violSqN, violLoadSqN, violStoreSqN,
    input wire [`FETCHID_W-1:0] violFetchID,
    input wire [`HIST_W-1:0] violHistory,
    input wire [`REG_IDX_W-1:0] violRIdx,
    input wire trapTaken,
    input wire trapFlush,
    input wire [`PC_W-1:0] trapDstPC,
    input wire [`SQN_W-1:0] trapSqN, trapLoadSqN, trapStoreSqN,
    input wire [`FETCHID_W-1:0] trapFetchID,
    input wire [`HIST_W-1:0] trapHistory,
    input wire [`REG_IDX_W-1:0] trapRIdx,
    input wire mispredFlush,
    output logic redirTaken,
    output logic redirFlush,
    output logic [`PC_W-1:0] redirDstPC,
    output logic [`SQN_W-1:0] redirSqN,
    output logic [`SQN_W-1:0] redirLoadSqN,
    output logic [`SQN_W-1:0] redirStoreSqN,
    output logic [`FETCHID_W-1:0] redirFetchID,
    output logic [`HIST_W-1:0] redirHistory,
    output logic [`REG_IDX_W-1:0] redirRIdx,
    output logic branchMispr
);
    logic br0Taken, br1Taken;
    logic [`PC_W-1:0] br0DstPC, br1DstPC;
    logic [`SQN_W-1:0] br0SqN, br0LoadSqN, br0StoreSqN;
    logic [`SQN_W-1:0] br1SqN, br1LoadSqN, br1StoreSqN;
    logic [`FETCHID_W-1:0] br0FetchID, br1FetchID;
    logic [`HIST_W-1:0] br0History, br1History;
    logic [`REG_IDX_W-1:0] br0RIdx, br1RIdx;

    BranchUnit unit0 (
        .clk(clk), .rst(rst), .issueValid(u0IssueValid), .instr(u0Instr), .pc(u0Pc),
        .srcA(u0SrcA), .srcB(u0SrcB), .predTaken(u0PredTaken), .predTarget(u0PredTarget),
        .sqN(u0SqN), .loadSqN(u0LoadSqN), .storeSqN(u0StoreSqN), .fetchID(u0FetchID),
        .history(u0History), .rIdx(u0RIdx), .redirTaken(redirTaken), .redirSqN(redirSqN),
        .brTaken(br0Taken), .brDstPC(br0DstPC), .brSqN(br0SqN), .brLoadSqN(br0LoadSqN),
        .brStoreSqN(br0StoreSqN), .brFetchID(br0FetchID), .brHistory(br0History),
        .brRIdx(br0RIdx)
    );

    BranchUnit unit1 (
        .clk(clk), .rst(rst), .issueValid(u1IssueValid), .instr(u1Instr), .pc(u1Pc),
        .srcA(u1SrcA), .srcB(u1SrcB), .predTaken(u1PredTaken), .predTarget(u1PredTarget),
        .sqN(u1SqN), .loadSqN(u1LoadSqN), .storeSqN(u1StoreSqN), .fetchID(u1FetchID),
        .history(u1History), .rIdx(u1RIdx), .redirTaken(redirTaken), .redirSqN(redirSqN),
        .brTaken(br1Taken), .brDstPC(br1DstPC), .brSqN(br1SqN), .brLoadSqN(br1LoadSqN),
        .brStoreSqN(br1StoreSqN), .brFetchID(br1FetchID), .brHistory(br1History),
        .brRIdx(br1RIdx)
    );

    // Slot order sets priority. Slot 3 is the ROB trap.
    BranchSelector selector (
        .clk(clk), .rst(rst), .mispredFlush(mispredFlush),
        .slot0Taken(br0Taken), .slot1Taken(br1Taken),
        .slot2Taken(violTaken), .slot3Taken(trapTaken), .slot3Flush(trapFlush),
        .slot0DstPC(br0DstPC), .slot1DstPC(br1DstPC),
        .slot2DstPC(violDstPC), .slot3DstPC(trapDstPC),
        .slot0SqN(br0SqN), .slot1SqN(br1SqN), .slot2SqN(violSqN), .slot3SqN(trapSqN),
        .slot0LoadSqN(br0LoadSqN), .slot1LoadSqN(br1LoadSqN),
        .slot2LoadSqN(violLoadSqN), .slot3LoadSqN(trapLoadSqN),
        .slot0StoreSqN(br0StoreSqN), .slot1StoreSqN(br1StoreSqN),
        .slot2StoreSqN(violStoreSqN), .slot3StoreSqN(trapStoreSqN),
        .slot0FetchID(br0FetchID), .slot1FetchID(br1FetchID),
        .slot2FetchID(violFetchID), .slot3FetchID(trapFetchID),
        .slot0History(br0History), .slot1History(br1History),
        .slot2History(violHistory), .slot3History(trapHistory),
        .slot0RIdx(br0RIdx), .slot1RIdx(br1RIdx), .slot2RIdx(violRIdx), .slot3RIdx(trapRIdx),
        .redirTaken(redirTaken), .redirFlush(redirFlush), .redirDstPC(redirDstPC),
        .redirSqN(redirSqN), .redirLoadSqN(redirLoadSqN), .redirStoreSqN(redirStoreSqN),
        .redirFetchID(redirFetchID), .redirHistory(redirHistory), .redirRIdx(redirRIdx),
        .branchMispr(branchMispr)
    );

endmodule

`default_nettype wire

//--- src/BranchSelector.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_macros.svh"

module BranchSelector (
    input wire clk,
    input wire rst,
    input wire mispredFlush,
    input wire slot0Taken, slot1Taken, slot2Taken, slot3Taken,
    input wire slot3Flush,
    input wire [`PC_W-1:0] slot0DstPC, slot1DstPC, slot2DstPC, slot3DstPC,
    input wire [`SQN_W-1:0] slot0SqN, slot1SqN, slot2SqN, slot3SqN,
    input wire [`SQN_W-1:0] slot0LoadSqN, slot1LoadSqN, slot2LoadSqN, slot3LoadSqN,
    input wire [`SQN_W-1:0] slot0StoreSqN, slot1StoreSqN, slot2StoreSqN, slot3StoreSqN,
    input wire [`FETCHID_W-1:0] slot0FetchID, slot1FetchID, slot2FetchID, slot3FetchID,
    input wire [`HIST_W-1:0] slot0History, slot1History, slot2History, slot3History,
    input wire [`REG_IDX_W-1:0] slot0RIdx, slot1RIdx, slot2RIdx, slot3RIdx,
    output logic redirTaken,
    output logic redirFlush,
    output logic [`PC_W-1:0] redirDstPC,
    output logic [`SQN_W-1:0] redirSqN,
    output logic [`SQN_W-1:0] redirLoadSqN,
    output logic [`SQN_W-1:0] redirStoreSqN,
    output logic [`FETCHID_W-1:0] redirFetchID,
    output logic [`HIST_W-1:0] redirHistory,
    output logic [`REG_IDX_W-1:0] redirRIdx,
    output logic branchMispr
);
    localparam int SEL_W = $clog2(`NUM_REDIRECT_SRC);
    localparam int TRAP = `NUM_REDIRECT_SRC - 1; // Highest slot always wins.

    logic [`NUM_REDIRECT_SRC-1:0] taken, eligible;
    logic [`PC_W-1:0] dstPC [`NUM_REDIRECT_SRC];
    logic [`SQN_W-1:0] sqN [`NUM_REDIRECT_SRC];
    logic [`SQN_W-1:0] loadSqN [`NUM_REDIRECT_SRC];
    logic [`SQN_W-1:0] storeSqN [`NUM_REDIRECT_SRC];
    logic [`FETCHID_W-1:0] fetchID [`NUM_REDIRECT_SRC];
    logic [`HIST_W-1:0] history [`NUM_REDIRECT_SRC];
    logic [`REG_IDX_W-1:0] rIdx [`NUM_REDIRECT_SRC];

    logic [`SQN_W-1:0] flushSqN; // Last redirect sent.
    logic [SEL_W-1:0] sel;

    function automatic logic isOlder(input logic [`SQN_W-1:0] a, input logic [`SQN_W-1:0] b);
        return $signed(a - b) < 0; // Wrap-around safe.
    endfunction

    assign taken = {slot3Taken, slot2Taken, slot1Taken, slot0Taken};
    assign dstPC = '{slot0DstPC, slot1DstPC, slot2DstPC, slot3DstPC};
    assign sqN = '{slot0SqN, slot1SqN, slot2SqN, slot3SqN};
    assign loadSqN = '{slot0LoadSqN, slot1LoadSqN, slot2LoadSqN, slot3LoadSqN};
    assign storeSqN = '{slot0StoreSqN, slot1StoreSqN, slot2StoreSqN, slot3StoreSqN};
    assign fetchID = '{slot0FetchID, slot1FetchID, slot2FetchID, slot3FetchID};
    assign history = '{slot0History, slot1History, slot2History, slot3History};
    assign rIdx = '{slot0RIdx, slot1RIdx, slot2RIdx, slot3RIdx};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Oldest eligible redirect
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int i = 0; i < `NUM_REDIRECT_SRC; i++) begin
            eligible[i] = taken[i] && (!mispredFlush || isOlder(sqN[i], flushSqN));
        end
    end

    always_comb begin
        sel = '0;
        redirTaken = 1'b0;
        for (int i = 0; i < TRAP; i++) begin
            if (eligible[i] && (!redirTaken || isOlder(sqN[i], sqN[sel]))) begin
                sel = SEL_W'(i);
                redirTaken = 1'b1;
            end
        end
        if (eligible[TRAP]) begin
            sel = SEL_W'(TRAP);
            redirTaken = 1'b1;
        end
    end

    assign redirFlush = redirTaken && sel == SEL_W'(TRAP) && slot3Flush;
    assign redirDstPC = dstPC[sel];
    assign redirSqN = sqN[sel];
    assign redirLoadSqN = loadSqN[sel];
    assign redirStoreSqN = storeSqN[sel];
    assign redirFetchID = fetchID[sel];
    assign redirHistory = history[sel];
    assign redirRIdx = rIdx[sel];

    // Genuine mispredicts only, not replays during a flush.
    assign branchMispr = redirTaken && sel < SEL_W'(2) && !mispredFlush;

    always_ff @(posedge clk) begin
        if (rst) begin
            flushSqN <= '0;
        end else if (redirTaken) begin
            flushSqN <= redirSqN;
        end
    end

endmodule

`default_nettype wire

//--- src/BranchUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_macros.svh"

module BranchUnit (
    input wire clk,
    input wire rst,
    input wire issueValid,
    input wire BranchPkg::BranchInstr instr,
    input wire [`PC_W-1:0] pc,
    input wire [`XLEN-1:0] srcA,
    input wire [`XLEN-1:0] srcB,
    input wire predTaken,
    input wire [`PC_W-1:0] predTarget,
    input wire [`SQN_W-1:0] sqN,
    input wire [`SQN_W-1:0] loadSqN,
    input wire [`SQN_W-1:0] storeSqN,
    input wire [`FETCHID_W-1:0] fetchID,
    input wire [`HIST_W-1:0] history,
    input wire [`REG_IDX_W-1:0] rIdx,
    input wire redirTaken,
    input wire [`SQN_W-1:0] redirSqN,
    output logic brTaken,
    output logic [`PC_W-1:0] brDstPC,
    output logic [`SQN_W-1:0] brSqN,
    output logic [`SQN_W-1:0] brLoadSqN,
    output logic [`SQN_W-1:0] brStoreSqN,
    output logic [`FETCHID_W-1:0] brFetchID,
    output logic [`HIST_W-1:0] brHistory,
    output logic [`REG_IDX_W-1:0] brRIdx
);
    import BranchPkg::*;

    BranchCond decCond;
    logic [`PC_W-1:0] decTarget;

    logic s1Valid;
    BranchCond s1Cond;
    logic [`PC_W-1:0] s1Target, s1Pc, s1PredTarget;
    logic [`XLEN-1:0] s1SrcA, s1SrcB;
    logic s1PredTaken;
    logic [`SQN_W-1:0] s1SqN, s1LoadSqN, s1StoreSqN;
    logic [`FETCHID_W-1:0] s1FetchID;
    logic [`HIST_W-1:0] s1History;
    logic [`REG_IDX_W-1:0] s1RIdx;

    logic killIssue, killS1;
    logic actTaken, mispr;
    logic [`PC_W-1:0] actNextPC;

    BranchDecoder decoder (
        .instr(instr), .pc(pc), .srcA(srcA),
        .cond(decCond), .imm(), .isIndirect(), .target(decTarget)
    );

    // An older redirect flushes everything younger in the unit.
    assign killIssue = redirTaken && $signed(redirSqN - sqN) < 0;
    assign killS1 = redirTaken && $signed(redirSqN - s1SqN) < 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 1: decoded op and operands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= issueValid && !killIssue;
        end
    end

    always_ff @(posedge clk) begin
        s1Cond <= decCond;
        s1Target <= decTarget;
        s1Pc <= pc;
        s1SrcA <= srcA;
        s1SrcB <= srcB;
        s1PredTaken <= predTaken;
        s1PredTarget <= predTarget;
        s1SqN <= sqN;
        s1LoadSqN <= loadSqN;
        s1StoreSqN <= storeSqN;
        s1FetchID <= fetchID;
        s1History <= history;
        s1RIdx <= rIdx;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 2: resolve and compare with the prediction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (s1Cond)
            COND_EQ: actTaken = s1SrcA == s1SrcB;
            COND_NE: actTaken = s1SrcA != s1SrcB;
            COND_LT: actTaken = $signed(s1SrcA) < $signed(s1SrcB);
            COND_GE: actTaken = $signed(s1SrcA) >= $signed(s1SrcB);
            COND_LTU: actTaken = s1SrcA < s1SrcB;
            COND_GEU: actTaken = s1SrcA >= s1SrcB;
            default: actTaken = 1'b1;
        endcase
    end

    assign actNextPC = actTaken ? s1Target : s1Pc + `PC_W'(4);
    assign mispr = (actTaken != s1PredTaken) || (actNextPC != s1PredTarget);

    always_ff @(posedge clk) begin
        if (rst) begin
            brTaken <= 1'b0;
        end else begin
            brTaken <= s1Valid && mispr && !killS1;
        end
    end

    always_ff @(posedge clk) begin
        brDstPC <= actNextPC;
        brSqN <= s1SqN;
        brLoadSqN <= s1LoadSqN;
        brStoreSqN <= s1StoreSqN;
        brFetchID <= s1FetchID;
        brHistory <= {s1History[`HIST_W-2:0], actTaken}; // Corrected history.
        brRIdx <= s1RIdx;
    end

endmodule

`default_nettype wire
